//--- hw/mm_geom_pkg.sv
package mm_geom_pkg;

  // matrix geometry
  localparam int LANES   = 4;   // int8 elements per memory word
  localparam int MAX_DIM = 16;  // largest m, n or p

  // memory geometry
  localparam int WORD_W    = 32;
  localparam int ADDR_W    = 8;
  localparam int MEM_DEPTH = 256;

  // one matrix dimension as carried in the command words
  typedef logic [15:0] dim_t;

  typedef logic [WORD_W-1:0] word_t;
  typedef logic [ADDR_W-1:0] addr_t;

  // signed element and signed accumulator
  typedef logic signed [7:0]  lane_t;
  typedef logic signed [31:0] acc_t;

  // one enable per byte lane
  typedef logic [LANES-1:0] lane_we_t;

endpackage

//--- hw/mm_ctrl_pkg.sv
package mm_ctrl_pkg;

  // word addresses inside the control memory
  localparam mm_geom_pkg::addr_t ADDR_FLAG = mm_geom_pkg::addr_t'(0);
  localparam mm_geom_pkg::addr_t ADDR_COM1 = mm_geom_pkg::addr_t'(1);  // {p, m}
  localparam mm_geom_pkg::addr_t ADDR_COM2 = mm_geom_pkg::addr_t'(2);  // {0, n}

  // flag word codes, host writes start, engine writes busy and finish
  localparam mm_geom_pkg::word_t FLAG_START  = 32'h5a5a_0001;
  localparam mm_geom_pkg::word_t FLAG_BUSY   = 32'h5a5a_0002;
  localparam mm_geom_pkg::word_t FLAG_FINISH = 32'h5a5a_0003;

  // one-hot host sequencer states
  typedef enum logic [7:0] {
    SEQ_IDLE       = 8'b0000_0001,
    SEQ_WRITE_FM   = 8'b0000_0010,
    SEQ_WRITE_WM   = 8'b0000_0100,
    SEQ_WRITE_COM  = 8'b0000_1000,
    SEQ_WRITE_FLAG = 8'b0001_0000,
    SEQ_WAIT_FLAG  = 8'b0010_0000,
    SEQ_READ_OUT   = 8'b0100_0000,
    SEQ_FINISH     = 8'b1000_0000
  } seq_state_t;

  // command words as two dimensions
  typedef struct packed {
    mm_geom_pkg::dim_t p;   // zero in command word 2
    mm_geom_pkg::dim_t mn;  // m in command word 1, n in command word 2
  } ctrl_dims_t;

  // same control word, seen as dimensions or as a flag code
  typedef union packed {
    ctrl_dims_t         dims;
    mm_geom_pkg::word_t raw;
  } ctrl_word_u;

endpackage

//--- hw/mm_mem_if.sv
interface mm_mem_if;

  mm_geom_pkg::lane_we_t we;     // one bit per byte lane
  mm_geom_pkg::addr_t    addr;
  mm_geom_pkg::word_t    wdata;
  mm_geom_pkg::word_t    rdata;  // word at the address of the previous edge

  modport host (
    output we, addr, wdata,
    input  rdata
  );

  modport mem (
    input  we, addr, wdata,
    output rdata
  );

endinterface

//--- hw/mm_dpram.sv
module mm_dpram (
  input  logic               arm_clk,
  mm_mem_if.mem              a,
  input  logic               b_we,
  input  mm_geom_pkg::addr_t b_addr,
  input  mm_geom_pkg::word_t b_wdata,
  output mm_geom_pkg::word_t b_rdata
);

  mm_geom_pkg::word_t mem [mm_geom_pkg::MEM_DEPTH];

  // both ports in one block, port b wins a same-address collision
  always_ff @(posedge arm_clk) begin
    for (int l = 0; l < mm_geom_pkg::LANES; l++) begin
      if (a.we[l]) begin
        mem[a.addr][l*(mm_geom_pkg::WORD_W/mm_geom_pkg::LANES) +:
                    (mm_geom_pkg::WORD_W/mm_geom_pkg::LANES)] <=
          a.wdata[l*(mm_geom_pkg::WORD_W/mm_geom_pkg::LANES) +:
                  (mm_geom_pkg::WORD_W/mm_geom_pkg::LANES)];
      end
    end
    if (b_we) begin
      mem[b_addr] <= b_wdata;  // whole word only
    end
    // registered reads, old data on a write to the same word
    a.rdata <= mem[a.addr];
    b_rdata <= mem[b_addr];
  end

endmodule

//--- hw/mm_host_seq.sv
module mm_host_seq (
  input  logic               arm_clk,
  input  logic               rst,
  input  logic               start,
  input  mm_geom_pkg::dim_t  m,
  input  mm_geom_pkg::dim_t  n,
  input  mm_geom_pkg::dim_t  p,
  input  logic               load_valid,
  input  mm_geom_pkg::word_t load_data,
  output logic               load_ready,
  output logic               busy,
  output logic               result_valid,
  output mm_geom_pkg::word_t result_data,
  output logic               done,
  mm_mem_if.host             fm_a,
  mm_mem_if.host             wm_a,
  mm_mem_if.host             ctrl_a,
  mm_mem_if.host             out_a
);

  mm_ctrl_pkg::seq_state_t state;
  mm_ctrl_pkg::seq_state_t state_nxt;
  mm_geom_pkg::dim_t       m_q;
  mm_geom_pkg::dim_t       n_q;
  mm_geom_pkg::dim_t       p_q;
  mm_geom_pkg::dim_t       cnt;        // shared word counter
  mm_geom_pkg::dim_t       fm_words;
  mm_geom_pkg::dim_t       wm_words;
  mm_geom_pkg::dim_t       out_words;
  logic                    accept;
  logic                    poll_q;
  logic                    rd_issue;
  logic                    rd_v1;
  mm_ctrl_pkg::ctrl_word_u cmd_w;
  mm_ctrl_pkg::ctrl_word_u flag_r;

  // keeps the memory images inside their depth
  function automatic mm_geom_pkg::dim_t clamp_dim(input mm_geom_pkg::dim_t d);
    if (d > mm_geom_pkg::dim_t'(mm_geom_pkg::MAX_DIM)) begin
      return mm_geom_pkg::dim_t'(mm_geom_pkg::MAX_DIM);
    end
    return d;
  endfunction

  // words per matrix, ceil(x/4) per row of k
  assign fm_words  = n_q * ((m_q + 16'd3) >> 2);
  assign wm_words  = n_q * ((p_q + 16'd3) >> 2);
  assign out_words = m_q * p_q;

  assign load_ready = (state == mm_ctrl_pkg::SEQ_WRITE_FM) ||
                      (state == mm_ctrl_pkg::SEQ_WRITE_WM);
  assign accept     = load_valid && load_ready;
  assign busy       = (state != mm_ctrl_pkg::SEQ_IDLE);
  assign done       = (state == mm_ctrl_pkg::SEQ_FINISH);
  assign rd_issue   = (state == mm_ctrl_pkg::SEQ_READ_OUT) && (cnt < out_words);
  assign flag_r     = ctrl_a.rdata;

  always_comb begin
    state_nxt = state;
    case (state)
      mm_ctrl_pkg::SEQ_IDLE:
        if (start) state_nxt = mm_ctrl_pkg::SEQ_WRITE_FM;
      mm_ctrl_pkg::SEQ_WRITE_FM:
        if (accept && cnt == fm_words - 16'd1) state_nxt = mm_ctrl_pkg::SEQ_WRITE_WM;
      mm_ctrl_pkg::SEQ_WRITE_WM:
        if (accept && cnt == wm_words - 16'd1) state_nxt = mm_ctrl_pkg::SEQ_WRITE_COM;
      mm_ctrl_pkg::SEQ_WRITE_COM:
        if (cnt == 16'd1) state_nxt = mm_ctrl_pkg::SEQ_WRITE_FLAG;
      mm_ctrl_pkg::SEQ_WRITE_FLAG:
        state_nxt = mm_ctrl_pkg::SEQ_WAIT_FLAG;
      mm_ctrl_pkg::SEQ_WAIT_FLAG:
        // first poll cycle still sees the word from before the start write
        if (poll_q && flag_r.raw == mm_ctrl_pkg::FLAG_FINISH) begin
          state_nxt = mm_ctrl_pkg::SEQ_READ_OUT;
        end
      mm_ctrl_pkg::SEQ_READ_OUT:
        if (cnt == out_words + 16'd1) state_nxt = mm_ctrl_pkg::SEQ_FINISH;  // 2 drain cycles
      mm_ctrl_pkg::SEQ_FINISH:
        state_nxt = mm_ctrl_pkg::SEQ_IDLE;
      default:
        state_nxt = mm_ctrl_pkg::SEQ_IDLE;
    endcase
  end

  always_ff @(posedge arm_clk or posedge rst) begin
    if (rst) begin
      state        <= mm_ctrl_pkg::SEQ_IDLE;
      cnt          <= '0;
      poll_q       <= 1'b0;
      rd_v1        <= 1'b0;
      result_valid <= 1'b0;
    end else begin
      state <= state_nxt;
      if (state_nxt != state) begin
        cnt <= '0;  // every state starts counting from zero
      end else if (accept || state == mm_ctrl_pkg::SEQ_WRITE_COM ||
                   state == mm_ctrl_pkg::SEQ_READ_OUT) begin
        cnt <= cnt + 16'd1;
      end
      poll_q       <= (state == mm_ctrl_pkg::SEQ_WAIT_FLAG);
      rd_v1        <= rd_issue;  // read data in the memory output register
      result_valid <= rd_v1;
    end
  end

  always_ff @(posedge arm_clk) begin
    if (state == mm_ctrl_pkg::SEQ_IDLE && start) begin
      m_q <= clamp_dim(m);
      n_q <= clamp_dim(n);
      p_q <= clamp_dim(p);
    end
    if (rd_v1) begin
      result_data <= out_a.rdata;
    end
  end

  // load stream straight into the feature and weight memories
  assign fm_a.we    = {mm_geom_pkg::LANES{accept && state == mm_ctrl_pkg::SEQ_WRITE_FM}};
  assign fm_a.addr  = cnt[mm_geom_pkg::ADDR_W-1:0];
  assign fm_a.wdata = load_data;
  assign wm_a.we    = {mm_geom_pkg::LANES{accept && state == mm_ctrl_pkg::SEQ_WRITE_WM}};
  assign wm_a.addr  = cnt[mm_geom_pkg::ADDR_W-1:0];
  assign wm_a.wdata = load_data;

  // command words, start flag, then flag polling
  always_comb begin
    cmd_w       = '0;
    ctrl_a.we   = '0;
    ctrl_a.addr = mm_ctrl_pkg::ADDR_FLAG;
    case (state)
      mm_ctrl_pkg::SEQ_WRITE_COM: begin
        ctrl_a.we = '1;
        if (cnt[0] == 1'b0) begin
          ctrl_a.addr  = mm_ctrl_pkg::ADDR_COM1;
          cmd_w.dims.p  = p_q;
          cmd_w.dims.mn = m_q;
        end else begin
          ctrl_a.addr  = mm_ctrl_pkg::ADDR_COM2;
          cmd_w.dims.mn = n_q;
        end
      end
      mm_ctrl_pkg::SEQ_WRITE_FLAG: begin
        ctrl_a.we = '1;
        cmd_w.raw = mm_ctrl_pkg::FLAG_START;
      end
      default: begin
      end
    endcase
    ctrl_a.wdata = cmd_w.raw;
  end

  // output memory is read only from this side
  assign out_a.we    = '0;
  assign out_a.addr  = cnt[mm_geom_pkg::ADDR_W-1:0];
  assign out_a.wdata = '0;

endmodule

//--- hw/mm_engine.sv
module mm_engine (
  input  logic               arm_clk,
  input  logic               rst,
  output logic               ctrl_we,
  output mm_geom_pkg::addr_t ctrl_addr,
  output mm_geom_pkg::word_t ctrl_wdata,
  input  mm_geom_pkg::word_t ctrl_rdata,
  output mm_geom_pkg::addr_t fm_addr,
  input  mm_geom_pkg::word_t fm_rdata,
  output mm_geom_pkg::addr_t wm_addr,
  input  mm_geom_pkg::word_t wm_rdata,
  output logic               out_we,
  output mm_geom_pkg::addr_t out_addr,
  output mm_geom_pkg::word_t out_wdata
);

  typedef enum logic [2:0] {
    ENG_POLL, ENG_BUSY, ENG_CMD1, ENG_CMD2, ENG_CMD3, ENG_RUN, ENG_DRAIN, ENG_FIN
  } eng_state_t;

  typedef logic [$clog2(mm_geom_pkg::MAX_DIM)-1:0] idx_t;
  typedef logic [$clog2(mm_geom_pkg::LANES)-1:0]   lane_sel_t;

  eng_state_t              state;
  eng_state_t              state_nxt;
  mm_geom_pkg::dim_t       m_q;
  mm_geom_pkg::dim_t       n_q;
  mm_geom_pkg::dim_t       p_q;
  mm_geom_pkg::dim_t       mw;       // feature words per k
  mm_geom_pkg::dim_t       pw;       // weight words per k
  mm_geom_pkg::dim_t       fm_idx;
  mm_geom_pkg::dim_t       wm_idx;
  mm_geom_pkg::dim_t       o_idx;
  idx_t                    i;
  idx_t                    j;
  idx_t                    k;
  logic                    i_last;
  logic                    j_last;
  logic                    k_last;
  logic                    v1;       // read in flight
  logic                    last1;
  lane_sel_t               il1;
  lane_sel_t               jl1;
  mm_geom_pkg::addr_t      oaddr1;
  mm_geom_pkg::lane_t      fa;
  mm_geom_pkg::lane_t      wb;
  mm_geom_pkg::acc_t       acc;
  mm_geom_pkg::acc_t       acc_nxt;
  mm_ctrl_pkg::ctrl_word_u cmd_r;

  assign cmd_r = ctrl_rdata;

  assign mw = (m_q + mm_geom_pkg::dim_t'(mm_geom_pkg::LANES - 1)) /
              mm_geom_pkg::dim_t'(mm_geom_pkg::LANES);
  assign pw = (p_q + mm_geom_pkg::dim_t'(mm_geom_pkg::LANES - 1)) /
              mm_geom_pkg::dim_t'(mm_geom_pkg::LANES);

  assign i_last = (mm_geom_pkg::dim_t'(i) == m_q - 16'd1);
  assign j_last = (mm_geom_pkg::dim_t'(j) == p_q - 16'd1);
  assign k_last = (mm_geom_pkg::dim_t'(k) == n_q - 16'd1);

  // word holding A[i][k] and B[k][j]
  assign fm_idx  = mm_geom_pkg::dim_t'(k) * mw +
                   mm_geom_pkg::dim_t'(i) / mm_geom_pkg::dim_t'(mm_geom_pkg::LANES);
  assign wm_idx  = mm_geom_pkg::dim_t'(k) * pw +
                   mm_geom_pkg::dim_t'(j) / mm_geom_pkg::dim_t'(mm_geom_pkg::LANES);
  assign o_idx   = mm_geom_pkg::dim_t'(i) * p_q + mm_geom_pkg::dim_t'(j);
  assign fm_addr = fm_idx[mm_geom_pkg::ADDR_W-1:0];
  assign wm_addr = wm_idx[mm_geom_pkg::ADDR_W-1:0];

  always_comb begin
    state_nxt = state;
    case (state)
      ENG_POLL:  if (cmd_r.raw == mm_ctrl_pkg::FLAG_START) state_nxt = ENG_BUSY;
      ENG_BUSY:  state_nxt = ENG_CMD1;
      ENG_CMD1:  state_nxt = ENG_CMD2;
      ENG_CMD2:  state_nxt = ENG_CMD3;
      ENG_CMD3:  state_nxt = ENG_RUN;
      ENG_RUN:   if (i_last && j_last && k_last) state_nxt = ENG_DRAIN;
      ENG_DRAIN: state_nxt = ENG_FIN;  // last sum stored here
      default:   state_nxt = ENG_POLL;
    endcase
  end

  // control memory side
  assign ctrl_we = (state == ENG_BUSY) || (state == ENG_FIN);
  always_comb begin
    case (state)
      ENG_CMD1: ctrl_addr = mm_ctrl_pkg::ADDR_COM1;
      ENG_CMD2: ctrl_addr = mm_ctrl_pkg::ADDR_COM2;
      default:  ctrl_addr = mm_ctrl_pkg::ADDR_FLAG;
    endcase
    ctrl_wdata = (state == ENG_FIN) ? mm_ctrl_pkg::FLAG_FINISH : mm_ctrl_pkg::FLAG_BUSY;
  end

  always_ff @(posedge arm_clk or posedge rst) begin
    if (rst) begin
      state <= ENG_POLL;
      i     <= '0;
      j     <= '0;
      k     <= '0;
      v1    <= 1'b0;
      acc   <= '0;
    end else begin
      state <= state_nxt;
      v1    <= (state == ENG_RUN);
      if (v1) begin
        acc <= last1 ? '0 : acc_nxt;  // clear after each stored sum
      end
      if (state == ENG_CMD3) begin
        i <= '0;
        j <= '0;
        k <= '0;
      end else if (state == ENG_RUN) begin
        // k innermost, then j, then i
        if (!k_last) begin
          k <= k + 1'b1;
        end else begin
          k <= '0;
          if (!j_last) begin
            j <= j + 1'b1;
          end else begin
            j <= '0;
            i <= i + 1'b1;
          end
        end
      end
    end
  end

  // command decode and stage-1 payload
  always_ff @(posedge arm_clk) begin
    if (state == ENG_CMD2) begin
      m_q <= cmd_r.dims.mn;  // command word 1 on the bus now
      p_q <= cmd_r.dims.p;
    end
    if (state == ENG_CMD3) begin
      n_q <= cmd_r.dims.mn;
    end
    last1  <= k_last;
    il1    <= i[$clog2(mm_geom_pkg::LANES)-1:0];
    jl1    <= j[$clog2(mm_geom_pkg::LANES)-1:0];
    oaddr1 <= o_idx[mm_geom_pkg::ADDR_W-1:0];
  end

  // lane select and signed multiply-accumulate
  assign fa      = mm_geom_pkg::lane_t'(fm_rdata[il1*$bits(mm_geom_pkg::lane_t) +:
                                                 $bits(mm_geom_pkg::lane_t)]);
  assign wb      = mm_geom_pkg::lane_t'(wm_rdata[jl1*$bits(mm_geom_pkg::lane_t) +:
                                                 $bits(mm_geom_pkg::lane_t)]);
  assign acc_nxt = acc + mm_geom_pkg::acc_t'(fa) * mm_geom_pkg::acc_t'(wb);

  assign out_we    = v1 && last1;
  assign out_addr  = oaddr1;
  assign out_wdata = acc_nxt;

endmodule

//--- hw/mm_top.sv
module mm_top (
  input  logic               arm_clk,
  input  logic               rst,
  input  logic               start,
  input  mm_geom_pkg::dim_t  m,
  input  mm_geom_pkg::dim_t  n,
  input  mm_geom_pkg::dim_t  p,
  input  logic               load_valid,
  input  mm_geom_pkg::word_t load_data,
  output logic               load_ready,
  output logic               busy,
  output logic               result_valid,
  output mm_geom_pkg::word_t result_data,
  output logic               done
);

  // engine side of the memories
  logic               ctrl_we_b;
  mm_geom_pkg::addr_t ctrl_addr_b;
  mm_geom_pkg::word_t ctrl_wdata_b;
  mm_geom_pkg::word_t ctrl_rdata_b;
  mm_geom_pkg::addr_t fm_addr_b;
  mm_geom_pkg::word_t fm_rdata_b;
  mm_geom_pkg::addr_t wm_addr_b;
  mm_geom_pkg::word_t wm_rdata_b;
  logic               out_we_b;
  mm_geom_pkg::addr_t out_addr_b;
  mm_geom_pkg::word_t out_wdata_b;

  mm_mem_if fm_a ();
  mm_mem_if wm_a ();
  mm_mem_if ctrl_a ();
  mm_mem_if out_a ();

  mm_host_seq mm_host_seq_inst (
    .arm_clk      (arm_clk),
    .rst          (rst),
    .start        (start),
    .m            (m),
    .n            (n),
    .p            (p),
    .load_valid   (load_valid),
    .load_data    (load_data),
    .load_ready   (load_ready),
    .busy         (busy),
    .result_valid (result_valid),
    .result_data  (result_data),
    .done         (done),
    .fm_a         (fm_a.host),
    .wm_a         (wm_a.host),
    .ctrl_a       (ctrl_a.host),
    .out_a        (out_a.host)
  );

  mm_engine mm_engine_inst (
    .arm_clk    (arm_clk),
    .rst        (rst),
    .ctrl_we    (ctrl_we_b),
    .ctrl_addr  (ctrl_addr_b),
    .ctrl_wdata (ctrl_wdata_b),
    .ctrl_rdata (ctrl_rdata_b),
    .fm_addr    (fm_addr_b),
    .fm_rdata   (fm_rdata_b),
    .wm_addr    (wm_addr_b),
    .wm_rdata   (wm_rdata_b),
    .out_we     (out_we_b),
    .out_addr   (out_addr_b),
    .out_wdata  (out_wdata_b)
  );

  // feature and weight memories are read only from the engine
  mm_dpram mem_fm (
    .arm_clk (arm_clk), .a (fm_a.mem),
    .b_we (1'b0), .b_addr (fm_addr_b), .b_wdata ('0), .b_rdata (fm_rdata_b)
  );

  mm_dpram mem_wm (
    .arm_clk (arm_clk), .a (wm_a.mem),
    .b_we (1'b0), .b_addr (wm_addr_b), .b_wdata ('0), .b_rdata (wm_rdata_b)
  );

  mm_dpram mem_ctrl (
    .arm_clk (arm_clk), .a (ctrl_a.mem),
    .b_we (ctrl_we_b), .b_addr (ctrl_addr_b), .b_wdata (ctrl_wdata_b), .b_rdata (ctrl_rdata_b)
  );

  mm_dpram mem_out (
    .arm_clk (arm_clk), .a (out_a.mem),
    .b_we (out_we_b), .b_addr (out_addr_b), .b_wdata (out_wdata_b), .b_rdata ()
  );

endmodule

//--- testbench/mm_checker.sv
module mm_checker (
  input logic                    arm_clk,
  input logic                    rst,
  input logic                    load_ready,
  input logic                    busy,
  input logic                    result_valid,
  input logic                    done,
  input mm_ctrl_pkg::seq_state_t state
);

  // nothing moves while reset is held
  quiet_in_reset: assert property (
    @(posedge arm_clk) rst |-> !load_ready && !busy && !result_valid && !done
  ) else $error("outputs active while reset is asserted");

  // load stream only open in the two write states
  ready_only_loading: assert property (
    @(posedge arm_clk) disable iff (rst)
      !(state == mm_ctrl_pkg::SEQ_WRITE_FM || state == mm_ctrl_pkg::SEQ_WRITE_WM)
      |-> !load_ready
  ) else $error("load_ready high outside the load states");

  done_single_pulse: assert property (
    @(posedge arm_clk) disable iff (rst)
      done |=> !done && state == mm_ctrl_pkg::SEQ_IDLE
  ) else $error("done longer than one cycle or not followed by idle");

  results_while_busy: assert property (
    @(posedge arm_clk) disable iff (rst) result_valid |-> busy
  ) else $error("result_valid high while the sequencer is idle");

endmodule

bind mm_top mm_checker mm_checker_inst (
  .arm_clk      (arm_clk),
  .rst          (rst),
  .load_ready   (load_ready),
  .busy         (busy),
  .result_valid (result_valid),
  .done         (done),
  .state        (mm_host_seq_inst.state)
);

//--- testbench/mm_tb.sv
module mm_tb;

  localparam int JOB_TIMEOUT = 20000;  // cycles, 16x16x16 needs a few thousand

  logic               arm_clk;
  logic               rst;
  logic               start;
  mm_geom_pkg::dim_t  m;
  mm_geom_pkg::dim_t  n;
  mm_geom_pkg::dim_t  p;
  logic               load_valid;
  mm_geom_pkg::word_t load_data;
  logic               load_ready;
  logic               busy;
  logic               result_valid;
  mm_geom_pkg::word_t result_data;
  logic               done;

  int                 errors;
  int                 tests_passed;
  int                 tests_failed;
  bit                 timed_out;
  int                 a_mat [mm_geom_pkg::MAX_DIM][mm_geom_pkg::MAX_DIM];
  int                 b_mat [mm_geom_pkg::MAX_DIM][mm_geom_pkg::MAX_DIM];
  mm_geom_pkg::word_t load_q [$];  // feature words, then weight words
  int                 exp_q [$];   // row-major products

  mm_top mm_top_inst (
    .arm_clk      (arm_clk),
    .rst          (rst),
    .start        (start),
    .m            (m),
    .n            (n),
    .p            (p),
    .load_valid   (load_valid),
    .load_data    (load_data),
    .load_ready   (load_ready),
    .busy         (busy),
    .result_valid (result_valid),
    .result_data  (result_data),
    .done         (done)
  );

  always #4 arm_clk = ~arm_clk;

  function automatic int rand_elem();
    return int'($urandom % 256) - 128;  // signed byte range
  endfunction

  // pack one matrix into words of four lanes, junk in the padding lanes
  task automatic pack_matrix(input bit is_a, input int rows, input int nn);
    mm_geom_pkg::word_t w;
    int                 e;
    for (int k = 0; k < nn; k++) begin
      for (int wi = 0; wi < (rows + 3) / 4; wi++) begin
        for (int l = 0; l < mm_geom_pkg::LANES; l++) begin
          e = wi * 4 + l;
          if (e >= rows) w[l*8 +: 8] = 8'($urandom);
          else if (is_a) w[l*8 +: 8] = 8'(a_mat[e][k]);
          else w[l*8 +: 8] = 8'(b_mat[k][e]);
        end
        load_q.push_back(w);
      end
    end
  endtask

  task automatic build_job(input int mm, input int nn, input int pp);
    int sum;
    load_q.delete();
    exp_q.delete();
    for (int i = 0; i < mm; i++)
      for (int k = 0; k < nn; k++) a_mat[i][k] = rand_elem();
    for (int k = 0; k < nn; k++)
      for (int j = 0; j < pp; j++) b_mat[k][j] = rand_elem();
    pack_matrix(1'b1, mm, nn);
    pack_matrix(1'b0, pp, nn);
    for (int i = 0; i < mm; i++) begin
      for (int j = 0; j < pp; j++) begin
        sum = 0;
        for (int k = 0; k < nn; k++) sum += a_mat[i][k] * b_mat[k][j];
        exp_q.push_back(sum);
      end
    end
  endtask

  task automatic check_quiet();
    repeat (4) begin
      @(negedge arm_clk);
      assert (!load_ready && !busy && !result_valid && !done) else begin
        $display("MISMATCH %0t: outputs not quiet after reset", $time);
        errors++;
      end
    end
  endtask

  task automatic start_job(input int mm, input int nn, input int pp);
    @(posedge arm_clk);
    start <= 1'b1;
    m     <= mm_geom_pkg::dim_t'(mm);
    n     <= mm_geom_pkg::dim_t'(nn);
    p     <= mm_geom_pkg::dim_t'(pp);
    @(posedge arm_clk);
    start <= 1'b0;  // sequencer is in write_fm from here
  endtask

  task automatic load_words();
    int idx;
    int cycles;
    idx    = 0;
    cycles = 0;
    while (idx < load_q.size() && !timed_out) begin
      @(posedge arm_clk);
      load_valid <= ($urandom % 4) != 0;  // random gaps
      load_data  <= load_q[idx];
      @(negedge arm_clk);
      assert (load_ready) else begin
        $display("MISMATCH %0t: load_ready low after %0d of %0d words",
                 $time, idx, load_q.size());
        errors++;
      end
      if (load_valid && load_ready) idx++;
      cycles++;
      if (cycles > JOB_TIMEOUT) begin
        $display("timeout: load stream stalled at word %0d of %0d", idx, load_q.size());
        timed_out = 1'b1;
      end
    end
    // extra words must be refused
    repeat (3) begin
      @(posedge arm_clk);
      load_valid <= 1'b1;
      load_data  <= $urandom;
      @(negedge arm_clk);
      assert (!load_ready) else begin
        $display("MISMATCH %0t: word accepted after the last load word", $time);
        errors++;
      end
    end
    @(posedge arm_clk);
    load_valid <= 1'b0;
  endtask

  task automatic collect_results(input int mm, input int pp);
    int ridx;
    int cycles;
    bit seen_done;
    ridx      = 0;
    cycles    = 0;
    seen_done = 1'b0;
    while (!seen_done && !timed_out) begin
      @(negedge arm_clk);
      if (result_valid) begin
        assert (ridx < exp_q.size()) else begin
          $display("MISMATCH %0t: result %0d beyond %0d expected", $time, ridx, exp_q.size());
          errors++;
        end
        if (ridx < exp_q.size()) begin
          assert (result_data == mm_geom_pkg::word_t'(exp_q[ridx])) else begin
            $display("MISMATCH %0t: C[%0d][%0d] got %0d expected %0d", $time,
                     ridx / pp, ridx % pp, $signed(result_data), exp_q[ridx]);
            errors++;
          end
        end
        ridx++;
      end
      if (done) begin
        seen_done = 1'b1;
        assert (ridx == mm * pp) else begin
          $display("MISMATCH %0t: %0d results before done, expected %0d", $time, ridx, mm * pp);
          errors++;
        end
      end
      cycles++;
      if (cycles > JOB_TIMEOUT) begin
        $display("timeout: no done pulse within %0d cycles", JOB_TIMEOUT);
        timed_out = 1'b1;
      end
    end
    if (seen_done) begin
      @(negedge arm_clk);
      assert (!busy && !done) else begin
        $display("MISMATCH %0t: busy or done still high after the done pulse", $time);
        errors++;
      end
    end
  endtask

  task automatic report_test(input int id, input string what, input int errors_before);
    if (errors == errors_before && !timed_out) begin
      tests_passed++;
      $display("test %0d %s: ok", id, what);
    end else begin
      tests_failed++;
      $display("test %0d %s: failed", id, what);
    end
  endtask

  task automatic run_job(input int id, input int mm, input int nn, input int pp);
    int errors_before;
    errors_before = errors;
    build_job(mm, nn, pp);
    start_job(mm, nn, pp);
    load_words();
    if (!timed_out) collect_results(mm, pp);
    report_test(id, $sformatf("job %0dx%0dx%0d", mm, nn, pp), errors_before);
  endtask

  initial begin
    int rm;
    int rn;
    int rp;
    void'($urandom(72746));
    arm_clk      = 1'b0;
    rst          = 1'b1;
    start        = 1'b0;
    m            = '0;
    n            = '0;
    p            = '0;
    load_valid   = 1'b0;
    load_data    = '0;
    errors       = 0;
    tests_passed = 0;
    tests_failed = 0;
    timed_out    = 1'b0;
    repeat (16) @(posedge arm_clk);
    rst <= 1'b0;
    check_quiet();
    report_test(0, "quiet after reset", 0);
    // back to back, full size first, then ragged lanes
    if (!timed_out) run_job(1, 16, 16, 16);
    if (!timed_out) run_job(2, 5, 3, 7);
    for (int t = 3; t < 5; t++) begin
      rm = 1 + int'($urandom % 16);
      rn = 1 + int'($urandom % 16);
      rp = 1 + int'($urandom % 16);
      if (!timed_out) run_job(t, rm, rn, rp);
    end
    $display("tests passed %0d, failed %0d, check errors %0d",
             tests_passed, tests_failed, errors);
    if (tests_failed == 0 && errors == 0 && !timed_out) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- vlog.f
hw/mm_geom_pkg.sv
hw/mm_ctrl_pkg.sv
hw/mm_mem_if.sv
hw/mm_dpram.sv
hw/mm_host_seq.sv
hw/mm_engine.sv
hw/mm_top.sv
testbench/mm_checker.sv
testbench/mm_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module mm_tb -f vlog.f -Mdir obj_dir

out=$(./obj_dir/Vmm_tb 2>&1 || true)
echo "$out"

if echo "$out" | grep -q "TEST PASSED"; then
  exit 0
fi
exit 1
